//--- gate_alu.f
rtl/gate_alu_pkg.sv
rtl/ripple_adder.sv
rtl/ripple_subtractor.sv
rtl/magnitude_comparator.sv
rtl/result_stage.sv
rtl/gate_alu.sv
tests/gate_alu_tb.sv

//--- rtl/gate_alu.sv
`default_nettype none

module gate_alu (
  input  wire                         RESET,
  input  wire                         i_rst_n,
  input  wire                         i_valid,
  input  wire gate_alu_pkg::operand_t i_a,
  input  wire gate_alu_pkg::operand_t i_b,
  input  wire gate_alu_pkg::op_t      i_op,
  output wire                         o_valid,
  output wire gate_alu_pkg::operand_t o_result,
  output wire                         o_carry,
  output wire                         o_eq,
  output wire                         o_gt
);

  // combinational datapath results
  wire gate_alu_pkg::operand_t sum;
  wire                         carry;
  wire gate_alu_pkg::operand_t diff;
  wire                         borrow;
  wire                         cmp_eq;
  wire                         cmp_gt;

  ripple_adder u_adder (
    .i_a     (i_a),
    .i_b     (i_b),
    .o_sum   (sum),
    .o_carry (carry)
  );

  // computes i_a minus i_b
  ripple_subtractor u_subtractor (
    .i_a      (i_a),
    .i_b      (i_b),
    .o_diff   (diff),
    .o_borrow (borrow)
  );

  magnitude_comparator u_comparator (
    .i_a  (i_a),
    .i_b  (i_b),
    .o_eq (cmp_eq),
    .o_gt (cmp_gt)
  );

  // single register stage with one cycle latency
  result_stage u_result (
    .RESET    (RESET),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_sum    (sum),
    .i_carry  (carry),
    .i_diff   (diff),
    .i_borrow (borrow),
    .i_eq     (cmp_eq),
    .i_gt     (cmp_gt),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_carry  (o_carry),
    .o_eq     (o_eq),
    .o_gt     (o_gt)
  );

endmodule

`default_nettype wire

//--- rtl/gate_alu_pkg.sv
`default_nettype none

package gate_alu_pkg;

  // operand and result width
  localparam int OPERAND_WIDTH = 6;

  // width of the lower sub-comparator slice
  localparam int LOW_SLICE_WIDTH = 4;

  // operands, sums and differences
  typedef logic [OPERAND_WIDTH-1:0] operand_t;

  // operation code
  typedef logic [1:0] op_t;

  localparam op_t OP_ADD = 2'd0;
  localparam op_t OP_SUB = 2'd1;
  localparam op_t OP_CMP = 2'd2;
  // code 3 is reserved and yields all-zero outputs

endpackage

`default_nettype wire

//--- rtl/magnitude_comparator.sv
`default_nettype none

module magnitude_comparator (
  input  wire gate_alu_pkg::operand_t i_a,
  input  wire gate_alu_pkg::operand_t i_b,
  output wire                         o_eq,
  output wire                         o_gt
);

  localparam int TOP = gate_alu_pkg::OPERAND_WIDTH - 1;
  localparam int LOW = gate_alu_pkg::LOW_SLICE_WIDTH;

  // upper two bits resolved directly
  wire top_gt;
  wire top_eq;
  wire next_gt;
  wire next_eq;
  wire upper_gt;
  wire upper_eq;

  assign top_gt  = i_a[TOP] & ~i_b[TOP];
  assign top_eq  = ~(i_a[TOP] ^ i_b[TOP]);
  assign next_gt = i_a[TOP-1] & ~i_b[TOP-1];
  assign next_eq = ~(i_a[TOP-1] ^ i_b[TOP-1]);

  // top bit decides unless it matches
  assign upper_gt = top_gt | (top_eq & next_gt);
  assign upper_eq = top_eq & next_eq;

  // lower slice handed to the 4-bit sub-comparator
  wire [LOW-1:0] low_a;
  wire [LOW-1:0] low_b;
  wire [LOW-1:0] low_ne;
  wire [LOW-1:0] eq_above;
  wire [LOW-1:0] gt_term_n;
  wire           low_eq;
  wire           low_gt;

  assign low_a  = i_a[LOW-1:0];
  assign low_b  = i_b[LOW-1:0];
  assign low_ne = low_a ^ low_b;

  // all lower bits match
  assign low_eq = ~|low_ne;

  // no difference above the top bit of the slice
  assign eq_above[LOW-1] = 1'b1;

  for (genvar i = LOW - 1; i > 0; i--) begin : g_eq_chain
    assign eq_above[i-1] = eq_above[i] & ~low_ne[i];
  end

  // one nand term per bit, active only at the first differing bit
  for (genvar i = 0; i < LOW; i++) begin : g_gt_term
    assign gt_term_n[i] = ~(eq_above[i] & low_a[i] & ~low_b[i]);
  end

  // any active term means the lower slice of i_a is larger
  assign low_gt = ~&gt_term_n;

  // combine upper resolve with the lower slice
  assign o_eq = upper_eq & low_eq;
  assign o_gt = upper_gt | (upper_eq & low_gt);

endmodule

`default_nettype wire

//--- rtl/result_stage.sv
`default_nettype none

module result_stage (
  input  wire                         RESET,
  input  wire                         i_rst_n,
  input  wire                         i_valid,
  input  wire gate_alu_pkg::op_t      i_op,
  input  wire gate_alu_pkg::operand_t i_sum,
  input  wire                         i_carry,
  input  wire gate_alu_pkg::operand_t i_diff,
  input  wire                         i_borrow,
  input  wire                         i_eq,
  input  wire                         i_gt,
  output logic                        o_valid,
  output gate_alu_pkg::operand_t      o_result,
  output logic                        o_carry,
  output logic                        o_eq,
  output logic                        o_gt
);

  // values selected by the operation code
  gate_alu_pkg::operand_t sel_result;
  logic                   sel_carry;
  logic                   sel_eq;
  logic                   sel_gt;

  always_comb begin
    sel_result = '0;
    sel_carry  = 1'b0;
    sel_eq     = i_eq;
    sel_gt     = i_gt;
    case (i_op)
      gate_alu_pkg::OP_ADD: begin
        sel_result = i_sum;
        sel_carry  = i_carry;
      end
      gate_alu_pkg::OP_SUB: begin
        sel_result = i_diff;
        sel_carry  = i_borrow;
      end
      gate_alu_pkg::OP_CMP: begin
        // result and carry stay zero for a compare
        sel_result = '0;
      end
      default: begin
        // reserved code clears the flags as well
        sel_eq = 1'b0;
        sel_gt = 1'b0;
      end
    endcase
  end

  always_ff @(posedge RESET) begin
    if (!i_rst_n) begin
      o_valid  <= 1'b0;
      o_result <= '0;
      o_carry  <= 1'b0;
      o_eq     <= 1'b0;
      o_gt     <= 1'b0;
    end else begin
      o_valid <= i_valid;
      // data holds its last value between strobes
      if (i_valid) begin
        o_result <= sel_result;
        o_carry  <= sel_carry;
        o_eq     <= sel_eq;
        o_gt     <= sel_gt;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/ripple_adder.sv
`default_nettype none

module ripple_adder (
  input  wire gate_alu_pkg::operand_t i_a,
  input  wire gate_alu_pkg::operand_t i_b,
  output wire gate_alu_pkg::operand_t o_sum,
  output wire                         o_carry
);

  // carry out of each bit slice
  wire gate_alu_pkg::operand_t carry;

  // bit 0 is a half adder
  assign o_sum[0] = i_a[0] ^ i_b[0];
  assign carry[0] = i_a[0] & i_b[0];

  // full adders each taking the carry of the slice below
  for (genvar i = 1; i < gate_alu_pkg::OPERAND_WIDTH; i++) begin : g_full_add
    assign o_sum[i] = i_a[i] ^ i_b[i] ^ carry[i-1];
    // majority of the three inputs
    assign carry[i] = (i_a[i] & i_b[i])
                    | (i_b[i] & carry[i-1])
                    | (i_a[i] & carry[i-1]);
  end

  // carry out of the top slice
  assign o_carry = carry[gate_alu_pkg::OPERAND_WIDTH-1];

endmodule

`default_nettype wire

//--- rtl/ripple_subtractor.sv
`default_nettype none

module ripple_subtractor (
  input  wire gate_alu_pkg::operand_t i_a,
  input  wire gate_alu_pkg::operand_t i_b,
  output wire gate_alu_pkg::operand_t o_diff,
  output wire                         o_borrow
);

  // borrow out of each bit slice
  wire gate_alu_pkg::operand_t borrow;

  // bit 0 is a half subtractor
  assign o_diff[0] = i_a[0] ^ i_b[0];
  // borrow when minuend is 0 and subtrahend is 1
  assign borrow[0] = ~i_a[0] & i_b[0];

  // modified full subtractor for every higher bit
  for (genvar i = 1; i < gate_alu_pkg::OPERAND_WIDTH; i++) begin : g_full_sub
    wire bit_diff;
    wire a_low_nand;
    wire ripple_nand;

    // two cascaded xors form the difference
    assign bit_diff  = i_a[i] ^ i_b[i];
    assign o_diff[i] = bit_diff ^ borrow[i-1];

    // local borrow term goes low when a is 0 and b is 1
    assign a_low_nand = ~(~i_a[i] & i_b[i]);
    // incoming borrow passes through when the bits match
    assign ripple_nand = ~(borrow[i-1] & ~bit_diff);

    assign borrow[i] = ~(a_low_nand & ripple_nand);
  end

  // top slice borrow is set when i_a < i_b
  assign o_borrow = borrow[gate_alu_pkg::OPERAND_WIDTH-1];

endmodule

`default_nettype wire

//--- tests/gate_alu_tb.sv
`default_nettype none

module gate_alu_tb;

  logic                   RESET;
  logic                   i_rst_n;
  logic                   i_valid;
  gate_alu_pkg::operand_t i_a;
  gate_alu_pkg::operand_t i_b;
  gate_alu_pkg::op_t      i_op;
  logic                   o_valid;
  gate_alu_pkg::operand_t o_result;
  logic                   o_carry;
  logic                   o_eq;
  logic                   o_gt;

  // random source and bookkeeping
  logic [31:0] lfsr_state;
  int          value_errors;
  int          protocol_errors;
  int          results_checked;

  // expected outputs packed as {result, carry, eq, gt}
  logic [8:0] exp_q[$];
  logic [8:0] held;
  logic [8:0] expected;
  logic       exp_valid;
  logic       armed;

  gate_alu i_dut (
    .RESET    (RESET),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_a      (i_a),
    .i_b      (i_b),
    .i_op     (i_op),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_carry  (o_carry),
    .o_eq     (o_eq),
    .o_gt     (o_gt)
  );

  always #20 RESET = ~RESET;

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] random_bits(int count);
    logic [31:0] value;
    value = '0;
    for (int n = 0; n < count; n++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
  endfunction

  function automatic gate_alu_pkg::operand_t random_operand();
    logic [31:0] value;
    value = random_bits(gate_alu_pkg::OPERAND_WIDTH);
    return value[gate_alu_pkg::OPERAND_WIDTH-1:0];
  endfunction

  function automatic gate_alu_pkg::op_t random_op();
    logic [31:0] value;
    value = random_bits(2);
    return value[1:0];
  endfunction

  // expected {result, carry, eq, gt} for one operation
  function automatic logic [8:0] ref_alu(gate_alu_pkg::operand_t a,
                                         gate_alu_pkg::operand_t b,
                                         gate_alu_pkg::op_t op);
    logic [6:0]             wide_sum;
    gate_alu_pkg::operand_t res;
    logic                   c;
    logic                   eq;
    logic                   gt;
    wide_sum = {1'b0, a} + {1'b0, b};
    eq  = (a == b);
    gt  = (a > b);
    res = '0;
    c   = 1'b0;
    case (op)
      gate_alu_pkg::OP_ADD: begin
        res = wide_sum[5:0];
        c   = wide_sum[6];
      end
      gate_alu_pkg::OP_SUB: begin
        res = a - b;
        c   = (a < b);
      end
      gate_alu_pkg::OP_CMP: begin
        res = '0;
      end
      default: begin
        eq = 1'b0;
        gt = 1'b0;
      end
    endcase
    return {res, c, eq, gt};
  endfunction

  task automatic check_operand(string name, gate_alu_pkg::operand_t got,
                               gate_alu_pkg::operand_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs(logic [8:0] exp);
    check_operand("o_result", o_result, exp[8:3]);
    check_flag("o_carry", o_carry, exp[2]);
    check_flag("o_eq", o_eq, exp[1]);
    check_flag("o_gt", o_gt, exp[0]);
  endtask

  // sample accepted operations where the inputs are stable
  always @(posedge RESET) begin
    if (!i_rst_n) begin
      exp_q.delete();
      exp_valid = 1'b0;
      held      = '0;
      armed     = 1'b1;
    end else begin
      exp_valid = i_valid;
      if (i_valid) begin
        exp_q.push_back(ref_alu(i_a, i_b, i_op));
      end
    end
  end

  // compare on the falling edge half a cycle after the outputs move
  always @(negedge RESET) begin
    if (armed) begin
      check_flag("o_valid", o_valid, exp_valid);
      if (o_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          protocol_errors++;
          $display("a result came out at %0t with no operation outstanding", $time);
        end else begin
          expected = exp_q.pop_front();
          held     = expected;
          check_outputs(expected);
          results_checked++;
        end
      end else begin
        // data must hold the last result
        check_outputs(held);
      end
    end
  end

  task automatic drive_op(gate_alu_pkg::operand_t a, gate_alu_pkg::operand_t b,
                          gate_alu_pkg::op_t op);
    @(negedge RESET);
    i_valid = 1'b1;
    i_a     = a;
    i_b     = b;
    i_op    = op;
  endtask

  // operands keep changing so that a held output is visible
  task automatic idle_cycle();
    @(negedge RESET);
    i_valid = 1'b0;
    i_a     = random_operand();
    i_b     = random_operand();
    i_op    = random_op();
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    idle_cycle();
    while (exp_q.size() != 0 && cycles < 10) begin
      @(posedge RESET);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      protocol_errors++;
      $display("timed out waiting for o_valid, %0d results never arrived", exp_q.size());
    end
  endtask

  task automatic finish_run();
    $display("errors: value %0d, protocol %0d, results checked %0d",
             value_errors, protocol_errors, results_checked);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin
    gate_alu_pkg::operand_t a;
    gate_alu_pkg::operand_t b;
    gate_alu_pkg::op_t      op;
    logic [3:0]             low;
    logic [1:0]             up_a;
    logic [1:0]             up_b;
    RESET           = 1'b0;
    i_rst_n         = 1'b0;
    i_valid         = 1'b0;
    i_a             = '0;
    i_b             = '0;
    i_op            = '0;
    lfsr_state      = 32'h9edc74bc;
    value_errors    = 0;
    protocol_errors = 0;
    results_checked = 0;
    exp_valid       = 1'b0;
    held            = '0;
    armed           = 1'b0;

    repeat (5) @(posedge RESET);
    @(negedge RESET);
    i_rst_n = 1'b1;
    // outputs stay cleared until the first strobe
    repeat (3) idle_cycle();

    // additions with the edge cases first
    drive_op(6'd0, 6'd0, gate_alu_pkg::OP_ADD);
    drive_op(6'd63, 6'd1, gate_alu_pkg::OP_ADD);
    drive_op(6'd63, 6'd63, gate_alu_pkg::OP_ADD);
    idle_cycle();
    for (int n = 0; n < 200; n++) begin
      drive_op(random_operand(), random_operand(), gate_alu_pkg::OP_ADD);
    end
    idle_cycle();

    // subtractions
    drive_op(6'd5, 6'd5, gate_alu_pkg::OP_SUB);
    drive_op(6'd0, 6'd1, gate_alu_pkg::OP_SUB);
    drive_op(6'd63, 6'd0, gate_alu_pkg::OP_SUB);
    drive_op(6'd32, 6'd33, gate_alu_pkg::OP_SUB);
    idle_cycle();
    for (int n = 0; n < 200; n++) begin
      drive_op(random_operand(), random_operand(), gate_alu_pkg::OP_SUB);
    end
    idle_cycle();

    // compares with upper bits differing, lower bits differing or all equal
    for (int n = 0; n < 16; n++) begin
      low  = random_bits(4);
      up_a = random_bits(2);
      up_b = up_a ^ (2'd1 + n[1:0] % 3);
      drive_op({up_a, low}, {up_b, low}, gate_alu_pkg::OP_CMP);
      a = random_operand();
      b = {a[5:4], a[3:0] ^ (4'd1 + n[3:0] % 15)};
      drive_op(a, b, gate_alu_pkg::OP_CMP);
      a = random_operand();
      drive_op(a, a, gate_alu_pkg::OP_CMP);
    end
    idle_cycle();
    idle_cycle();

    // back to back with every code including the reserved one
    for (int n = 0; n < 50; n++) begin
      op = (n % 10 == 7) ? 2'd3 : random_op();
      drive_op(random_operand(), random_operand(), op);
    end

    wait_drained();
    repeat (2) idle_cycle();
    finish_run();
  end

endmodule

`default_nettype wire
